// File: csr_types_pkg.sv
package csr_types_pkg;

    // opcode field of the command word
    typedef enum logic [1:0] {
        CSR_NOP = 2'b00,    // illegal as a command
        CSR_RW  = 2'b01,
        CSR_RS  = 2'b10,
        CSR_RC  = 2'b11
    } csr_op_e;

    // implemented machine-mode CSRs
    typedef enum logic [11:0] {
        ADDR_MSCRATCH = 12'h340,
        ADDR_MCYCLE   = 12'hB00,
        ADDR_MINSTRET = 12'hB02
    } csr_addr_e;

    // layout of CMD[19:0]
    typedef struct packed {
        csr_op_e     op;        // bits 19:18
        logic        use_imm;   // bit 17, source is imm instead of SRC
        logic [4:0]  imm;       // bits 16:12, zero-extended
        logic [11:0] addr;      // bits 11:0, may hold an unknown CSR
    } csr_cmd_t;

    typedef enum logic [1:0] {
        CNT_NONE     = 2'd0,
        CNT_MCYCLE   = 2'd1,
        CNT_MINSTRET = 2'd2
    } cnt_sel_e;

    // counter write, valid for the cycle in which sel is not CNT_NONE
    typedef struct packed {
        cnt_sel_e    sel;
        logic [31:0] data;
    } cnt_wr_t;

endpackage

// File: csr_bus_pkg.sv
package csr_bus_pkg;

    // wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;   // byte address within the register window
        logic [31:0] dat;
    } wb_req_t;

    // slave to master, no err or rty
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // register map
    localparam logic [3:0] REG_SRC    = 4'h0;   // source operand, write only
    localparam logic [3:0] REG_CMD    = 4'h4;   // write starts a CSR command
    localparam logic [3:0] REG_RESULT = 4'h8;   // old CSR value, read only
    localparam logic [3:0] REG_STATUS = 4'hC;   // bit 0 illegal, read only

endpackage

// File: csr_bus_fsm.sv
`timescale 1ns/1ps

module csr_bus_fsm (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_bus_pkg::wb_req_t wb_req,
    output csr_bus_pkg::wb_rsp_t wb_rsp,
    output logic                 src_we,
    output logic                 cmd_we,
    output logic                 exec,
    output logic [31:0]          wr_dat,
    input  logic [31:0]          result,
    input  logic [31:0]          status
);

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_EXEC = 2'd1,
        ST_ACK  = 2'd2
    } state_e;

    state_e      state;
    logic [3:0]  adr_q;
    logic        we_q;
    logic        accept;
    logic        is_cmd_wr;
    logic [31:0] read_dat;

    // while ack is out the master still holds stb for the finished access
    assign accept    = wb_req.cyc & wb_req.stb & ~wb_rsp.ack;
    assign is_cmd_wr = wb_req.we && (wb_req.adr == csr_bus_pkg::REG_CMD);

    always_comb begin
        read_dat = 32'd0;   // SRC, CMD and unmapped offsets read as zero
        if (!we_q) begin
            case (adr_q)
                csr_bus_pkg::REG_RESULT: read_dat = result;
                csr_bus_pkg::REG_STATUS: read_dat = status;
                default:                 read_dat = 32'd0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            src_we <= 1'b0;
            cmd_we <= 1'b0;
            exec   <= 1'b0;
            wr_dat <= 32'd0;
            adr_q  <= 4'd0;
            we_q   <= 1'b0;
            wb_rsp <= '0;
        end else begin
            src_we     <= 1'b0;     // strobes last one cycle
            cmd_we     <= 1'b0;
            exec       <= 1'b0;
            wb_rsp.ack <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        adr_q  <= wb_req.adr;
                        we_q   <= wb_req.we;
                        wr_dat <= wb_req.dat;
                        if (is_cmd_wr) begin
                            cmd_we <= 1'b1;
                            state  <= ST_EXEC;
                        end else begin
                            src_we <= wb_req.we && (wb_req.adr == csr_bus_pkg::REG_SRC);
                            state  <= ST_ACK;
                        end
                    end
                end

                ST_EXEC: begin
                    exec  <= 1'b1;          // CMD register is loaded by now
                    state <= ST_ACK;
                end

                ST_ACK: begin
                    // no ack if the master gave up on the access
                    wb_rsp.ack <= wb_req.cyc & wb_req.stb;
                    wb_rsp.dat <= read_dat;
                    state      <= ST_IDLE;
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: csr_cycle_counter.sv
`timescale 1ns/1ps

module csr_cycle_counter (
    input  logic                    clk,
    input  logic                    rst,
    input  csr_types_pkg::cnt_wr_t  cnt_wr,
    input  logic                    retire,
    output logic [31:0]             mcycle,
    output logic [31:0]             minstret
);

    logic        wr_mcycle;
    logic        wr_minstret;
    logic [31:0] mcycle_nxt;
    logic [31:0] minstret_nxt;

    assign wr_mcycle   = (cnt_wr.sel == csr_types_pkg::CNT_MCYCLE);
    assign wr_minstret = (cnt_wr.sel == csr_types_pkg::CNT_MINSTRET);

    // a write replaces the increment of that cycle
    always_comb begin
        if (wr_mcycle) begin
            mcycle_nxt = cnt_wr.data;
        end else begin
            mcycle_nxt = mcycle + 32'd1;
        end
    end

    always_comb begin
        if (wr_minstret) begin
            minstret_nxt = cnt_wr.data;     // the writing command does not count
        end else if (retire) begin
            minstret_nxt = minstret + 32'd1;
        end else begin
            minstret_nxt = minstret;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= 32'd0;
            minstret <= 32'd0;
        end else begin
            mcycle   <= mcycle_nxt;
            minstret <= minstret_nxt;
        end
    end

endmodule

// File: csr_op_unit.sv
`timescale 1ns/1ps

module csr_op_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    src_we,
    input  logic                    cmd_we,
    input  logic                    exec,
    input  logic [31:0]             wr_dat,
    input  logic [31:0]             mcycle,
    input  logic [31:0]             minstret,
    output csr_types_pkg::cnt_wr_t  cnt_wr,
    output logic                    retire,
    output logic [31:0]             result,
    output logic [31:0]             status
);

    csr_types_pkg::csr_cmd_t cmd_q;
    logic [31:0]             src_q;
    logic [31:0]             mscratch;
    logic [31:0]             old_val;
    logic [31:0]             wr_val;
    logic [31:0]             new_val;
    logic                    addr_ok;
    logic                    legal;
    logic                    do_write;

    // address decode and old value
    always_comb begin
        addr_ok = 1'b1;
        old_val = 32'd0;
        case (cmd_q.addr)
            csr_types_pkg::ADDR_MSCRATCH: old_val = mscratch;
            csr_types_pkg::ADDR_MCYCLE:   old_val = mcycle;
            csr_types_pkg::ADDR_MINSTRET: old_val = minstret;
            default:                      addr_ok = 1'b0;
        endcase
    end

    assign wr_val = cmd_q.use_imm ? {27'd0, cmd_q.imm} : src_q;

    always_comb begin
        case (cmd_q.op)
            csr_types_pkg::CSR_RW: new_val = wr_val;
            csr_types_pkg::CSR_RS: new_val = old_val | wr_val;
            csr_types_pkg::CSR_RC: new_val = old_val & ~wr_val;
            default:               new_val = old_val;
        endcase
    end

    assign legal    = addr_ok && (cmd_q.op != csr_types_pkg::CSR_NOP);
    // set and clear with a zero source only read
    assign do_write = legal && ((cmd_q.op == csr_types_pkg::CSR_RW) || (wr_val != 32'd0));

    assign retire = exec & legal;

    always_comb begin
        cnt_wr.sel  = csr_types_pkg::CNT_NONE;
        cnt_wr.data = new_val;
        if (exec && do_write) begin
            if (cmd_q.addr == csr_types_pkg::ADDR_MCYCLE) begin
                cnt_wr.sel = csr_types_pkg::CNT_MCYCLE;
            end else if (cmd_q.addr == csr_types_pkg::ADDR_MINSTRET) begin
                cnt_wr.sel = csr_types_pkg::CNT_MINSTRET;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            src_q    <= 32'd0;
            cmd_q    <= '0;
            mscratch <= 32'd0;
            result   <= 32'd0;
            status   <= 32'd0;
        end else begin
            if (src_we) begin
                src_q <= wr_dat;
            end
            if (cmd_we) begin
                cmd_q <= csr_types_pkg::csr_cmd_t'(wr_dat[19:0]);  // upper bits dropped
            end
            if (exec) begin
                result <= legal ? old_val : 32'd0;
                status <= {31'd0, ~legal};
                if (do_write && (cmd_q.addr == csr_types_pkg::ADDR_MSCRATCH)) begin
                    mscratch <= new_val;
                end
            end
        end
    end

endmodule

// File: csr_sys_top.sv
`timescale 1ns/1ps

module csr_sys_top (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_bus_pkg::wb_req_t wb_req,
    output csr_bus_pkg::wb_rsp_t wb_rsp
);

    logic                   src_we;
    logic                   cmd_we;
    logic                   exec;
    logic [31:0]            wr_dat;
    logic [31:0]            result;
    logic [31:0]            status;
    csr_types_pkg::cnt_wr_t cnt_wr;
    logic                   retire;
    logic [31:0]            mcycle;
    logic [31:0]            minstret;

    csr_bus_fsm i_bus_fsm (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .src_we (src_we),
        .cmd_we (cmd_we),
        .exec   (exec),
        .wr_dat (wr_dat),
        .result (result),
        .status (status)
    );

    csr_op_unit i_op_unit (
        .clk      (clk),
        .rst      (rst),
        .src_we   (src_we),
        .cmd_we   (cmd_we),
        .exec     (exec),
        .wr_dat   (wr_dat),
        .mcycle   (mcycle),
        .minstret (minstret),
        .cnt_wr   (cnt_wr),
        .retire   (retire),
        .result   (result),
        .status   (status)
    );

    csr_cycle_counter i_cycle_counter (
        .clk      (clk),
        .rst      (rst),
        .cnt_wr   (cnt_wr),
        .retire   (retire),
        .mcycle   (mcycle),
        .minstret (minstret)
    );

endmodule

// File: tb_csr_sys.sv
`timescale 1ns/1ps

module tb_csr_sys;

    localparam int ACK_TIMEOUT = 50;

    logic                 clk;
    logic                 rst;
    csr_bus_pkg::wb_req_t wb_req;
    csr_bus_pkg::wb_rsp_t wb_rsp;

    int          errors;
    int          checks;
    logic        timed_out;
    integer      seed;
    logic [31:0] model_mscratch;
    logic [31:0] model_minstret;

    csr_sys_top i_dut (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input logic [31:0] tol, input string what);
        logic ok;
        checks++;
        if (tol == 32'd0) begin
            ok = (actual === expected);
        end else begin
            ok = !$isunknown(actual) && (actual >= expected) && (actual - expected <= tol);
        end
        if (!ok) begin
            errors++;
            $display("Mismatch at %0t: %s, got %h, expected %h (+%h)",
                     $time, what, actual, expected, tol);
        end
    endtask

    // one classic access that starts 1 ns after a rising edge
    task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int waited;
        waited     = 0;
        rdat       = 32'd0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
        if (wb_rsp.ack) begin
            rdat = wb_rsp.dat;
        end else begin
            $display("no acknowledge from the bus at %0t, offset %h", $time, adr);
            errors++;
            timed_out = 1'b1;
        end
        wb_req = '0;
        @(posedge clk);
        #1;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] wdat);
        logic [31:0] discard;
        bus_cycle(1'b1, adr, wdat, discard);
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] rdat);
        bus_cycle(1'b0, adr, 32'd0, rdat);
    endtask

    task automatic run_command(input logic [31:0] src, input logic [31:0] cmd);
        wb_write(csr_bus_pkg::REG_SRC, src);
        if (!timed_out) begin
            wb_write(csr_bus_pkg::REG_CMD, cmd);
        end
    endtask

    task automatic read_results(output logic [31:0] res, output logic [31:0] st);
        st = 32'd0;
        wb_read(csr_bus_pkg::REG_RESULT, res);
        if (!timed_out) begin
            wb_read(csr_bus_pkg::REG_STATUS, st);
        end
    endtask

    // expected mscratch and minstret behavior without mcycle
    task automatic model_command(input logic [31:0] src, input logic [31:0] cmd,
                                 output logic [31:0] exp_res, output logic [31:0] exp_st);
        logic [1:0]  op;
        logic [11:0] addr;
        logic [31:0] operand;
        logic [31:0] old;
        logic [31:0] upd;
        logic        known;
        op      = cmd[19:18];
        addr    = cmd[11:0];
        operand = cmd[17] ? {27'd0, cmd[16:12]} : src;
        known   = 1'b1;
        case (addr)
            12'h340: old = model_mscratch;
            12'hB02: old = model_minstret;
            12'hB00: old = 32'd0;
            default: begin
                old   = 32'd0;
                known = 1'b0;
            end
        endcase
        case (op)
            2'b01:   upd = operand;
            2'b10:   upd = old | operand;
            default: upd = old & ~operand;
        endcase
        if (!known || op == 2'b00) begin
            exp_res = 32'd0;
            exp_st  = 32'd1;
        end else begin
            exp_res        = old;
            exp_st         = 32'd0;
            model_minstret = model_minstret + 32'd1;
            if (op == 2'b01 || operand != 32'd0) begin
                if (addr == 12'h340) begin
                    model_mscratch = upd;
                end else if (addr == 12'hB02) begin
                    model_minstret = upd;       // write wins over the retire count
                end
            end
        end
    endtask

    task automatic run_and_compare(input logic [31:0] src, input logic [31:0] cmd,
                                   input string what);
        logic [31:0] exp_res;
        logic [31:0] exp_st;
        logic [31:0] res;
        logic [31:0] st;
        model_command(src, cmd, exp_res, exp_st);
        run_command(src, cmd);
        read_results(res, st);
        if (!timed_out) begin
            check_value(res, exp_res, 32'd0, {what, " RESULT"});
            check_value(st, exp_st, 32'd0, {what, " STATUS"});
        end
    endtask

    task automatic run_patterns();
        int           fd;
        int           n;
        int           row;
        logic [7:0]   kind;
        logic [8*128-1:0] line;
        logic [31:0]  src;
        logic [31:0]  cmd;
        logic [31:0]  exp_res;
        logic [31:0]  exp_st;
        logic [31:0]  tol;
        logic [31:0]  res;
        logic [31:0]  st;
        logic [31:0]  m_res;
        logic [31:0]  m_st;
        row = 0;
        fd  = $fopen("csr_sys_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file csr_sys_patterns.txt");
            errors++;
        end else begin
            while (!timed_out && !$feof(fd)) begin
                n = $fscanf(fd, " %c", kind);
                if (n == 1 && kind == "#") begin
                    n = $fgets(line, fd);       // comment line
                end else if (n == 1) begin
                    row++;
                    n = $fscanf(fd, " %h %h %h %h %h", src, cmd, exp_res, exp_st, tol);
                    if (n != 5) begin
                        $display("pattern row %0d is malformed", row);
                        errors++;
                    end else begin
                        if (kind == "C") begin
                            model_command(src, cmd, m_res, m_st);
                            run_command(src, cmd);
                        end
                        read_results(res, st);
                        if (!timed_out) begin
                            check_value(res, exp_res, tol, $sformatf("row %0d RESULT", row));
                            check_value(st, exp_st, 32'd0, $sformatf("row %0d STATUS", row));
                            if (kind == "C" && tol == 32'd0) begin
                                check_value(res, m_res, 32'd0,
                                            $sformatf("row %0d model RESULT", row));
                                check_value(st, m_st, 32'd0,
                                            $sformatf("row %0d model STATUS", row));
                            end
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic random_mscratch_test(input int count);
        logic [31:0] src;
        logic [1:0]  op;
        int          pick;
        for (int i = 0; i < count; i++) begin
            if (!timed_out) begin
                src  = $random(seed);
                pick = {$random(seed)} % 3;
                op   = pick[1:0] + 2'd1;        // RW, RS or RC
                run_and_compare(src, {12'd0, op, 1'b0, 5'd0, 12'h340},
                                $sformatf("random %0d", i));
                run_and_compare(32'd0, 32'h0008_0340, $sformatf("readback %0d", i));
            end
        end
    endtask

    initial begin
        rst            = 1'b1;
        wb_req         = '0;
        errors         = 0;
        checks         = 0;
        timed_out      = 1'b0;
        seed           = 32'hb6b85ee3;
        model_mscratch = 32'd0;
        model_minstret = 32'd0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value({31'd0, wb_rsp.ack}, 32'd0, 32'd0, "ack after reset");

        run_patterns();
        random_mscratch_test(24);
        if (!timed_out) begin
            run_and_compare(32'd0, 32'h0008_0B02, "minstret at end");
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: csr_sys.f
csr_types_pkg.sv
csr_bus_pkg.sv
csr_bus_fsm.sv
csr_cycle_counter.sv
csr_op_unit.sv
csr_sys_top.sv
tb_csr_sys.sv

// File: Bender.yml
package:
  name: csr_sys

sources:
  - csr_types_pkg.sv
  - csr_bus_pkg.sv
  - csr_bus_fsm.sv
  - csr_cycle_counter.sv
  - csr_op_unit.sv
  - csr_sys_top.sv
  - target: test
    files:
      - tb_csr_sys.sv

// File: csr_sys_patterns.txt
# kind src cmd result status tolerance, all hex after the kind
# kind C runs SRC and CMD writes then reads back, kind R only reads RESULT and STATUS
# reset values
C 00000000 00080B02 00000000 0 0
C 00000000 00080340 00000000 0 0
R 00000000 00000000 00000000 0 0
# csrrw on mscratch with register and immediate sources
C 12345678 00040340 00000000 0 0
C 00000000 00080340 12345678 0 0
C deadbeef 00075340 12345678 0 0
C ffffffff 000A0340 00000015 0 0
# set and clear
C 0f0f0000 00080340 00000015 0 0
C 00000005 000C0340 0f0f0015 0 0
C 00000000 000F0340 0f0f0010 0 0
C 00000000 00080340 0f0f0000 0 0
# minstret counts retired commands
C 00000000 00080B02 0000000a 0 0
C 00000000 00080B02 0000000b 0 0
C 00000100 00040B02 0000000c 0 0
C 00000000 00080B02 00000100 0 0
# illegal opcode and unknown address
C 00000055 00000340 00000000 1 0
R 00000000 00000000 00000000 1 0
C 00000077 00040345 00000000 1 0
C 00000000 00080B02 00000101 0 0
C 00000000 00080340 0f0f0000 0 0
# mcycle write, then a read some cycles later
C 00001000 00040B00 00000000 0 10000
C 00000000 00080B00 00001001 0 3f
C 00000000 00080B02 00000105 0 0
